/* vlog.f */
src/pmp_pkg.sv
src/pmp_cfg_warl.sv
src/pmp_region_match.sv
src/pmp_access_check.sv
src/pmp_csr_regs.sv
src/pmp_top.sv
verif/pmp_clk_gen.sv
verif/pmp_checker.sv
verif/tb_pmp.sv

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --assert --top-module tb_pmp -f vlog.f -o sim_pmp
./obj_dir/sim_pmp | tee sim.log

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi

/* verif/tb_pmp.sv */
/*
  Directed testbench for the PMP unit. Drives the Wishbone port 1 ns after
  each rising edge, probes both checkers and prints one line per test and
  a closing summary.
*/
`timescale 1ns/1ps

module tb_pmp
  import pmp_pkg::*;
();

  logic        clk;
  logic        rst_n;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  priv_lvl_e   priv;
  logic [31:0] instr_addr;
  logic [31:0] data_addr;
  pmp_perm_t   instr_perm;
  pmp_perm_t   data_perm;
  int          errors;
  int          tests;
  int          seed;
  logic        bus_hung;

  pmp_clk_gen i_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  pmp_top #(
    .NUM_REGIONS (16),
    .GRANULARITY (2)
  ) i_dut (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .wb_req_i     (wb_req),
    .wb_rsp_o     (wb_rsp),
    .priv_i       (priv),
    .instr_addr_i (instr_addr),
    .data_addr_i  (data_addr),
    .instr_perm_o (instr_perm),
    .data_perm_o  (data_perm)
  );

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR %0t ns: %s read %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests++;
    if (errors == errs_before) begin
      $display("%-16s passed", name);
    end else begin
      $display("%-16s failed with %0d errors", name, errors - errs_before);
    end
  endtask

  // One classic cycle; stb drops on the edge after ack was seen
  task automatic bus_cycle(input logic we, input logic [11:0] adr, input logic [3:0] sel,
                           input logic [31:0] wdat, output logic [31:0] rdat);
    int   waited;
    logic got_ack;
    rdat = '0;
    if (!bus_hung) begin
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      wb_req.we  = we;
      wb_req.adr = adr;
      wb_req.sel = sel;
      wb_req.dat = wdat;
      waited  = 0;
      got_ack = 1'b0;
      while (!got_ack && waited < 20) begin
        @(posedge clk);
        #1;
        waited++;
        got_ack = wb_rsp.ack;
      end
      if (got_ack) begin
        rdat = wb_rsp.dat;
      end else begin
        $display("Timeout: no Wishbone ack within 20 cycles at address %h", adr);
        bus_hung = 1'b1;
        errors++;
      end
      @(posedge clk);
      #1;
      wb_req = '0;
    end
  endtask

  task automatic wb_write(input logic [11:0] adr, input logic [3:0] sel,
                          input logic [31:0] dat);
    logic [31:0] unused;
    bus_cycle(1'b1, adr, sel, dat, unused);
  endtask

  task automatic wb_read(input logic [11:0] adr, output logic [31:0] dat);
    bus_cycle(1'b0, adr, 4'hF, '0, dat);
  endtask

  task automatic read_expect(input string what, input logic [11:0] adr,
                             input logic [31:0] exp);
    logic [31:0] rdat;
    wb_read(adr, rdat);
    check(what, rdat, exp);
  endtask

  // Both checkers see the same address; outputs sampled one cycle later
  task automatic probe(input priv_lvl_e p, input logic [31:0] addr, input logic [2:0] exp);
    priv       = p;
    instr_addr = addr;
    data_addr  = addr;
    @(posedge clk);
    #1;
    check($sformatf("instr perm at %h", addr), 32'(instr_perm), 32'(exp));
    check($sformatf("data perm at %h", addr), 32'(data_perm), 32'(exp));
  endtask

  // TOR region 1 is bytes 1000..2fff read only, NAPOT region 2 is 2000..3fff RWX
  function automatic logic [2:0] overlap_perm(input logic [31:0] a);
    if (a >= 32'h1000 && a < 32'h3000) begin
      return 3'b100;
    end
    if (a >= 32'h2000 && a < 32'h4000) begin
      return 3'b111;
    end
    return 3'b000;
  endfunction

  task automatic test_reset_values();
    int e;
    e = errors;
    for (int k = 0; k < 4; k++) begin
      read_expect($sformatf("pmpcfg%0d", k), CSR_PMPCFG0 + 12'(k), '0);
    end
    for (int k = 0; k < 16; k++) begin
      read_expect($sformatf("pmpaddr%0d", k), CSR_PMPADDR0 + 12'(k), '0);
    end
    read_expect("mseccfg", CSR_MSECCFG, '0);
    for (int k = 0; k < 4; k++) begin
      probe(PRIV_U, $random(seed) & 32'hFFFF_FFFC, 3'b000);
      probe(PRIV_M, $random(seed) & 32'hFFFF_FFFC, 3'b111);
    end
    report_test("reset_values", e);
  endtask

  task automatic test_cfg_legal();
    int e;
    e = errors;
    wb_write(CSR_PMPCFG0 + 12'd1, 4'hF, 32'h0000_0105);
    read_expect("cfg1 initial", CSR_PMPCFG0 + 12'd1, 32'h0000_0105);
    // TOR with W only, previous RX stays
    wb_write(CSR_PMPCFG0 + 12'd1, 4'b0001, 32'h0707_070A);
    read_expect("cfg1 write-only", CSR_PMPCFG0 + 12'd1, 32'h0000_010D);
    // NA4 refused at this grain, RW taken
    wb_write(CSR_PMPCFG0 + 12'd1, 4'b0001, 32'h0707_0713);
    read_expect("cfg1 na4", CSR_PMPCFG0 + 12'd1, 32'h0000_010B);
    wb_write(CSR_PMPCFG0 + 12'd1, 4'b0001, 32'h0707_0761);
    read_expect("cfg1 zero bits", CSR_PMPCFG0 + 12'd1, 32'h0000_0101);
    wb_write(CSR_PMPCFG0 + 12'd1, 4'hF, '0);
    report_test("cfg_legal", e);
  endtask

  task automatic test_addr_view();
    int e;
    e = errors;
    wb_write(CSR_PMPADDR0 + 12'd4, 4'hF, 32'hFFFF_FFFF);
    read_expect("pmpaddr4 off", CSR_PMPADDR0 + 12'd4, 32'hFFFF_FFFC);
    wb_write(CSR_PMPCFG0 + 12'd1, 4'b0001, 32'h0000_0018);
    read_expect("pmpaddr4 napot", CSR_PMPADDR0 + 12'd4, 32'hFFFF_FFFF);
    wb_write(CSR_PMPCFG0 + 12'd1, 4'b0001, 32'h0000_0000);
    read_expect("pmpaddr4 off again", CSR_PMPADDR0 + 12'd4, 32'hFFFF_FFFC);
    report_test("addr_view", e);
  endtask

  task automatic test_priority();
    int          e;
    logic [31:0] a;
    e = errors;
    wb_write(CSR_PMPADDR0 + 12'd0, 4'hF, 32'h0000_0400);
    wb_write(CSR_PMPADDR0 + 12'd1, 4'hF, 32'h0000_0C00);
    wb_write(CSR_PMPADDR0 + 12'd2, 4'hF, 32'h0000_0BFF);
    wb_write(CSR_PMPCFG0, 4'hF, 32'h001F_0900);
    probe(PRIV_U, 32'h0000_0FFC, overlap_perm(32'h0000_0FFC));
    probe(PRIV_U, 32'h0000_3000, overlap_perm(32'h0000_3000));
    probe(PRIV_U, 32'h0000_4000, overlap_perm(32'h0000_4000));
    for (int k = 0; k < 24; k++) begin
      a = $random(seed) & 32'h0000_7FFC;
      probe(PRIV_U, a, overlap_perm(a));
    end
    wb_write(CSR_PMPCFG0, 4'hF, '0);
    report_test("priority", e);
  endtask

  task automatic test_rlb_unlock();
    int e;
    e = errors;
    wb_write(CSR_MSECCFG, 4'hF, 32'h0000_0004);
    read_expect("mseccfg rlb set", CSR_MSECCFG, 32'h0000_0004);
    wb_write(CSR_PMPCFG0 + 12'd2, 4'b0001, 32'h0000_0089);
    read_expect("cfg2 locked", CSR_PMPCFG0 + 12'd2, 32'h0000_0089);
    wb_write(CSR_PMPCFG0 + 12'd2, 4'b0001, 32'h0000_0003);
    read_expect("cfg2 rewritten", CSR_PMPCFG0 + 12'd2, 32'h0000_0003);
    wb_write(CSR_PMPCFG0 + 12'd2, 4'hF, '0);
    wb_write(CSR_MSECCFG, 4'hF, '0);
    read_expect("mseccfg rlb clear", CSR_MSECCFG, '0);
    report_test("rlb_unlock", e);
  endtask

  task automatic test_lock();
    int e;
    e = errors;
    wb_write(CSR_PMPADDR0 + 12'd8, 4'hF, 32'h0000_2000);
    wb_write(CSR_PMPADDR0 + 12'd9, 4'hF, 32'h0000_2400);
    wb_write(CSR_PMPCFG0 + 12'd2, 4'b0010, 32'h0000_8900);
    read_expect("cfg2 locked tor", CSR_PMPCFG0 + 12'd2, 32'h0000_8900);
    wb_write(CSR_PMPCFG0 + 12'd2, 4'b0010, 32'h0000_0F00);
    read_expect("cfg2 after rewrite", CSR_PMPCFG0 + 12'd2, 32'h0000_8900);
    wb_write(CSR_PMPADDR0 + 12'd9, 4'hF, 32'h0000_3000);
    read_expect("pmpaddr9 locked", CSR_PMPADDR0 + 12'd9, 32'h0000_2400);
    wb_write(CSR_PMPADDR0 + 12'd8, 4'hF, 32'h0000_3000);
    read_expect("pmpaddr8 below tor", CSR_PMPADDR0 + 12'd8, 32'h0000_2000);
    probe(PRIV_M, 32'h0000_8000, 3'b100);
    probe(PRIV_M, 32'h0000_8FFC, 3'b100);
    probe(PRIV_M, 32'h0000_9000, 3'b111);
    probe(PRIV_M, 32'h0000_7FFC, 3'b111);
    probe(PRIV_U, 32'h0000_8800, 3'b100);
    wb_write(CSR_MSECCFG, 4'hF, 32'h0000_0004);
    read_expect("mseccfg rlb refused", CSR_MSECCFG, '0);
    report_test("lock", e);
  endtask

  initial begin
    int waited;
    wb_req     = '0;
    priv       = PRIV_M;
    instr_addr = '0;
    data_addr  = '0;
    errors     = 0;
    tests      = 0;
    seed       = 32'h59491f96;
    bus_hung   = 1'b0;
    waited     = 0;
    while (rst_n !== 1'b1 && waited < 20) begin
      @(posedge clk);
      waited++;
    end
    if (rst_n !== 1'b1) begin
      $display("Reset was never released");
      bus_hung = 1'b1;
      errors++;
    end
    @(posedge clk);
    #1;
    test_reset_values();
    test_cfg_legal();
    test_addr_view();
    test_priority();
    // Locks stay until reset, so RLB runs before the lock test
    test_rlb_unlock();
    test_lock();
    $display("Tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* verif/pmp_checker.sv */
/*
  Bus and lock assertions for the PMP register file. Bound into every
  pmp_csr_regs instance by the bind directive at the end of this file.
*/
`timescale 1ns/1ps

module pmp_checker
  import pmp_pkg::*;
#(
  parameter int NUM_REGIONS = 16
) (
  input logic                       clk_i,
  input logic                       rst_ni,
  input wb_req_t                    wb_req_i,
  input wb_rsp_t                    wb_rsp_i,
  input pmp_cfg_t [NUM_REGIONS-1:0] cfg_i,
  input logic                       rlb_i
);

  ack_in_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_rsp_i.ack |-> (wb_req_i.cyc && wb_req_i.stb))
    else $error("ack raised outside a bus cycle");

  ack_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_rsp_i.ack |=> !wb_rsp_i.ack)
    else $error("ack held for two cycles");

  // Only RLB can open a locked entry
  for (genvar i = 0; i < NUM_REGIONS; i++) begin : gen_lock
    locked_cfg_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (cfg_i[i].lock && !rlb_i) |=> $stable(cfg_i[i]))
      else $error("locked configuration of region %0d changed", i);
  end

endmodule

bind pmp_csr_regs pmp_checker #(
  .NUM_REGIONS (NUM_REGIONS)
) i_checker (
  .clk_i    (clk_i),
  .rst_ni   (rst_ni),
  .wb_req_i (wb_req_i),
  .wb_rsp_i (wb_rsp_o),
  .cfg_i    (cfg_o),
  .rlb_i    (rlb_o)
);

/* verif/pmp_clk_gen.sv */
/*
  Clock and reset source for the PMP testbench. 10 ns clock, active-low
  reset held for the first four rising edges.
*/
`timescale 1ns/1ps

module pmp_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Release just after the fourth edge
  initial begin
    rst_no = 1'b0;
    repeat (4) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

/* src/pmp_top.sv */
/*
  PMP unit top level. The register file feeds one checker for the fetch
  address and one for the data address; software reaches the registers
  through the Wishbone port.
*/
`timescale 1ns/1ps

module pmp_top
  import pmp_pkg::*;
#(
  parameter int NUM_REGIONS = 16,
  parameter int GRANULARITY = 2
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  wb_req_t     wb_req_i,
  output wb_rsp_t     wb_rsp_o,
  input  priv_lvl_e   priv_i,
  input  logic [31:0] instr_addr_i,
  input  logic [31:0] data_addr_i,
  output pmp_perm_t   instr_perm_o,
  output pmp_perm_t   data_perm_o
);

  pmp_cfg_t [NUM_REGIONS-1:0]   cfg;
  logic [NUM_REGIONS-1:0][31:0] pmpaddr;

  pmp_csr_regs #(
    .NUM_REGIONS (NUM_REGIONS),
    .GRANULARITY (GRANULARITY)
  ) i_csr_regs (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wb_req_i (wb_req_i),
    .wb_rsp_o (wb_rsp_o),
    .cfg_o    (cfg),
    .addr_o   (pmpaddr),
    .rlb_o    ()
  );

  // Fetch side
  pmp_access_check #(
    .NUM_REGIONS (NUM_REGIONS),
    .GRANULARITY (GRANULARITY)
  ) i_instr_check (
    .addr_i    (instr_addr_i),
    .priv_i    (priv_i),
    .cfg_i     (cfg),
    .pmpaddr_i (pmpaddr),
    .perm_o    (instr_perm_o)
  );

  // Load and store side
  pmp_access_check #(
    .NUM_REGIONS (NUM_REGIONS),
    .GRANULARITY (GRANULARITY)
  ) i_data_check (
    .addr_i    (data_addr_i),
    .priv_i    (priv_i),
    .cfg_i     (cfg),
    .pmpaddr_i (pmpaddr),
    .perm_o    (data_perm_o)
  );

endmodule

/* src/pmp_csr_regs.sv */
/*
  PMP register file behind a Wishbone classic slave. Stores pmpcfg, pmpaddr
  and mseccfg, applies the lock and legal-value rules on writes, and returns
  the granularity view of pmpaddr on reads. Ack comes one cycle after strobe.
*/
`timescale 1ns/1ps

module pmp_csr_regs
  import pmp_pkg::*;
#(
  parameter int NUM_REGIONS = 16,
  parameter int GRANULARITY = 2
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  wb_req_t                      wb_req_i,
  output wb_rsp_t                      wb_rsp_o,
  output pmp_cfg_t [NUM_REGIONS-1:0]   cfg_o,
  output logic [NUM_REGIONS-1:0][31:0] addr_o,
  output logic                         rlb_o
);

  // Low address bits forced by the grain in the software view
  localparam logic [31:0] GRAIN_MASK = (32'd1 << GRANULARITY) - 32'd1;
  localparam logic [31:0] NAPOT_ONES = GRAIN_MASK >> 1;

  if ((NUM_REGIONS % 4 != 0) || (NUM_REGIONS > MAX_REGIONS)) begin : gen_param_check
    $error("NUM_REGIONS must be a multiple of 4 and at most %0d", MAX_REGIONS);
  end

  pmp_cfg_t [NUM_REGIONS-1:0]   cfg_q;
  pmp_cfg_t [NUM_REGIONS-1:0]   cfg_legal;
  logic [NUM_REGIONS-1:0][31:0] addr_q;
  logic [NUM_REGIONS-1:0][31:0] addr_rd;
  logic [NUM_REGIONS-1:0]       cfg_we;
  logic [NUM_REGIONS-1:0]       addr_we;
  logic [NUM_REGIONS-1:0]       lock_vec;
  logic [NUM_REGIONS-1:0]       tor_above;
  logic                         rlb_q;
  logic                         ack_q;
  logic [31:0]                  rdat_q;
  logic [31:0]                  rdata;
  logic                         access;
  logic                         wr_en;
  logic                         full_word;
  logic                         msec_we;
  mseccfg_t                     msec_wr;
  mseccfg_t                     msec_rd;

  // New transfer is sampled only while ack is low
  assign access    = wb_req_i.cyc && wb_req_i.stb && !ack_q;
  assign wr_en     = access && wb_req_i.we;
  assign full_word = (wb_req_i.sel == 4'hF);
  assign msec_wr   = mseccfg_t'(wb_req_i.dat);

  for (genvar i = 0; i < NUM_REGIONS; i++) begin : gen_region
    pmp_cfg_warl #(
      .GRANULARITY (GRANULARITY)
    ) i_cfg_warl (
      .cfg_prev_i (cfg_q[i]),
      .cfg_wr_i   (pmp_cfg_t'(wb_req_i.dat[8*(i%4) +: 8])),
      .rlb_i      (rlb_q),
      .cfg_o      (cfg_legal[i])
    );

    assign lock_vec[i] = cfg_q[i].lock;

    // A locked TOR region also protects the address below it
    if (i < NUM_REGIONS - 1) begin : gen_tor
      assign tor_above[i] = cfg_q[i+1].lock && (cfg_q[i+1].mode == PMP_TOR);
    end else begin : gen_last
      assign tor_above[i] = 1'b0;
    end

    assign cfg_we[i] = wr_en && wb_req_i.sel[i%4] &&
                       (wb_req_i.adr == CSR_PMPCFG0 + 12'(i / 4));
    assign addr_we[i] = wr_en && full_word &&
                        (wb_req_i.adr == CSR_PMPADDR0 + 12'(i)) &&
                        !(!rlb_q && (cfg_q[i].lock || tor_above[i]));

    // Software view, storage keeps the written value
    assign addr_rd[i] = (cfg_q[i].mode == PMP_NAPOT) ? (addr_q[i] | NAPOT_ONES) :
                        !cfg_q[i].mode[1]            ? (addr_q[i] & ~GRAIN_MASK) :
                                                        addr_q[i];
  end

  // Setting RLB is refused once something got locked without it
  assign msec_we = wr_en && full_word && (wb_req_i.adr == CSR_MSECCFG) &&
                   !(msec_wr.rlb && !rlb_q && (|lock_vec));

  always_comb begin
    msec_rd     = '0;
    msec_rd.rlb = rlb_q;
    rdata       = '0;
    for (int i = 0; i < NUM_REGIONS; i++) begin
      if (wb_req_i.adr == CSR_PMPCFG0 + 12'(i / 4)) begin
        rdata[8*(i%4) +: 8] = cfg_q[i];
      end
      if (wb_req_i.adr == CSR_PMPADDR0 + 12'(i)) begin
        rdata = addr_rd[i];
      end
    end
    if (wb_req_i.adr == CSR_MSECCFG) begin
      rdata = msec_rd;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q  <= 1'b0;
      rlb_q  <= 1'b0;
      cfg_q  <= '0;
      addr_q <= '0;
    end else begin
      ack_q <= access;
      for (int i = 0; i < NUM_REGIONS; i++) begin
        if (cfg_we[i]) begin
          cfg_q[i] <= cfg_legal[i];
        end
        if (addr_we[i]) begin
          addr_q[i] <= wb_req_i.dat;
        end
      end
      if (msec_we) begin
        rlb_q <= msec_wr.rlb;
      end
    end
  end

  // Read data captured with the ack
  always_ff @(posedge clk_i) begin
    if (access && !wb_req_i.we) begin
      rdat_q <= rdata;
    end
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.dat = rdat_q;
  assign cfg_o        = cfg_q;
  assign addr_o       = addr_q;
  assign rlb_o        = rlb_q;

endmodule

/* src/pmp_access_check.sv */
/*
  Permission check for one address. Each region is matched in parallel,
  the lowest-numbered match decides, and the privilege rules give the final
  read, write and exec grants. Purely combinational.
*/
`timescale 1ns/1ps

module pmp_access_check
  import pmp_pkg::*;
#(
  parameter int NUM_REGIONS = 16,
  parameter int GRANULARITY = 2
) (
  input  logic [31:0]                  addr_i,
  input  priv_lvl_e                    priv_i,
  input  pmp_cfg_t [NUM_REGIONS-1:0]   cfg_i,
  input  logic [NUM_REGIONS-1:0][31:0] pmpaddr_i,
  output pmp_perm_t                    perm_o
);

  logic [NUM_REGIONS-1:0] match;
  logic                   hit;
  pmp_cfg_t               hit_cfg;

  for (genvar i = 0; i < NUM_REGIONS; i++) begin : gen_match
    logic [31:0] base;

    // TOR of region 0 starts at address zero
    if (i == 0) begin : gen_base_zero
      assign base = '0;
    end else begin : gen_base_prev
      assign base = pmpaddr_i[i-1];
    end

    pmp_region_match #(
      .GRANULARITY (GRANULARITY)
    ) i_region_match (
      .addr_i    (addr_i),
      .cfg_i     (cfg_i[i]),
      .base_i    (base),
      .pmpaddr_i (pmpaddr_i[i]),
      .match_o   (match[i])
    );
  end

  // Walk downwards so the lowest index is the last to win
  always_comb begin
    hit     = 1'b0;
    hit_cfg = '0;
    for (int i = NUM_REGIONS - 1; i >= 0; i--) begin
      if (match[i]) begin
        hit     = 1'b1;
        hit_cfg = cfg_i[i];
      end
    end
  end

  always_comb begin
    perm_o = '0;
    if (priv_i == PRIV_M && !(hit && hit_cfg.lock)) begin
      // Machine mode is only bound by locked regions
      perm_o.read  = 1'b1;
      perm_o.write = 1'b1;
      perm_o.exec  = 1'b1;
    end else if (hit) begin
      perm_o.read  = hit_cfg.read;
      perm_o.write = hit_cfg.write;
      perm_o.exec  = hit_cfg.exec;
    end
  end

endmodule

/* src/pmp_region_match.sv */
/*
  Address match for a single PMP region. Handles TOR, NA4 and NAPOT with the
  configured grain; OFF never matches. Purely combinational.
*/
`timescale 1ns/1ps

module pmp_region_match
  import pmp_pkg::*;
#(
  parameter int GRANULARITY = 2
) (
  input  logic [31:0] addr_i,
  input  pmp_cfg_t    cfg_i,
  input  logic [31:0] base_i,
  input  logic [31:0] pmpaddr_i,
  output logic        match_o
);

  localparam logic [31:0] GRAIN_MASK = (32'd1 << GRANULARITY) - 32'd1;
  localparam logic [31:0] NAPOT_ONES = GRAIN_MASK >> 1;

  logic [31:0] word_addr;
  logic [31:0] tor_base;
  logic [31:0] tor_top;
  logic [31:0] napot_addr;
  logic [31:0] napot_span;

  // pmpaddr holds bits 33:2 of the physical address
  assign word_addr = {2'b00, addr_i[31:2]};

  // TOR bounds aligned to the grain
  assign tor_base = base_i & ~GRAIN_MASK;
  assign tor_top  = pmpaddr_i & ~GRAIN_MASK;

  // Trailing ones give the size, the grain sets a minimum
  assign napot_addr = pmpaddr_i | NAPOT_ONES;
  assign napot_span = napot_addr ^ (napot_addr + 32'd1);

  always_comb begin
    unique case (cfg_i.mode)
      PMP_TOR: begin
        match_o = (word_addr >= tor_base) && (word_addr < tor_top);
      end
      PMP_NA4: begin
        match_o = (word_addr == pmpaddr_i);
      end
      PMP_NAPOT: begin
        match_o = ((word_addr & ~napot_span) == (napot_addr & ~napot_span));
      end
      default: begin
        match_o = 1'b0;
      end
    endcase
  end

endmodule

/* src/pmp_cfg_warl.sv */
/*
  Legalizes a write to one pmpcfg byte. Purely combinational; the register
  file instantiates one per region and stores the result on a write.
*/
`timescale 1ns/1ps

module pmp_cfg_warl
  import pmp_pkg::*;
#(
  parameter int GRANULARITY = 2
) (
  input  pmp_cfg_t cfg_prev_i,
  input  pmp_cfg_t cfg_wr_i,
  input  logic     rlb_i,
  output pmp_cfg_t cfg_o
);

  logic locked;
  logic rw_reserved;
  logic na4_illegal;

  assign locked = cfg_prev_i.lock && !rlb_i;

  // W=1 with R=0 is reserved
  assign rw_reserved = cfg_wr_i.write && !cfg_wr_i.read;

  // NA4 only exists for a 4-byte grain
  assign na4_illegal = (GRANULARITY >= 1) && (cfg_wr_i.mode == PMP_NA4);

  always_comb begin
    cfg_o = cfg_wr_i;
    if (locked) begin
      cfg_o = cfg_prev_i;
    end else begin
      if (rw_reserved) begin
        cfg_o.exec  = cfg_prev_i.exec;
        cfg_o.write = cfg_prev_i.write;
        cfg_o.read  = cfg_prev_i.read;
      end
      if (na4_illegal) begin
        cfg_o.mode = cfg_prev_i.mode;
      end
    end
    // Hardwired zero field
    cfg_o.zero = 2'b00;
  end

endmodule

/* src/pmp_pkg.sv */
/*
  Shared types and constants for the PMP unit. Holds the configuration byte,
  permission and privilege encodings, the CSR numbers of the register port
  and the Wishbone request and response bundles.
*/
package pmp_pkg;

  // Largest region count that the CSR map has room for
  localparam int MAX_REGIONS = 16;

  // CSR numbers as seen on the Wishbone address
  localparam logic [11:0] CSR_PMPCFG0  = 12'h3A0;
  localparam logic [11:0] CSR_PMPADDR0 = 12'h3B0;
  localparam logic [11:0] CSR_MSECCFG  = 12'h747;

  // Address matching mode, field A of pmpcfg
  typedef enum logic [1:0] {
    PMP_OFF   = 2'b00,
    PMP_TOR   = 2'b01,
    PMP_NA4   = 2'b10,
    PMP_NAPOT = 2'b11
  } pmp_mode_e;

  // One region's configuration byte, same layout as in pmpcfg
  typedef struct packed {
    logic       lock;
    logic [1:0] zero;
    pmp_mode_e  mode;
    logic       exec;
    logic       write;
    logic       read;
  } pmp_cfg_t;

  // Permissions granted for one access
  typedef struct packed {
    logic read;
    logic write;
    logic exec;
  } pmp_perm_t;

  // Only user and machine mode exist on this core
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_M = 2'b11
  } priv_lvl_e;

  // mseccfg with only RLB implemented
  typedef struct packed {
    logic [28:0] zero_hi;
    logic        rlb;
    logic [1:0]  zero_lo;
  } mseccfg_t;

  // Master to slave
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [11:0] adr;
    logic [3:0]  sel;
    logic [31:0] dat;
  } wb_req_t;

  // Slave to master
  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

endpackage
